// ==== Makefile ====
# Verilator build and run of the video frame buffer testbench

SIM := obj_dir/Vtb_video_buffer

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): vlog.f $(wildcard hw/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing --assert -j 0 --top-module tb_video_buffer -f vlog.f

# the log decides pass or fail
run: $(SIM)
	./$(SIM) +verilator+error+limit+100 > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/tb_video_buffer.sv ====
`timescale 1ns/1ps

module tb_video_buffer;

    import video_pkg::*;

    localparam int H_ACTIVE        = DEF_H_ACTIVE;
    localparam int H_FRONT         = DEF_H_FRONT;
    localparam int H_SYNC          = DEF_H_SYNC;
    localparam int H_BACK          = DEF_H_BACK;
    localparam int V_ACTIVE        = DEF_V_ACTIVE;
    localparam int V_FRONT         = DEF_V_FRONT;
    localparam int V_SYNC          = DEF_V_SYNC;
    localparam int V_BACK          = DEF_V_BACK;
    localparam int DEBOUNCE_CYCLES = DEF_DEBOUNCE_CYCLES;

    localparam int H_TOTAL      = H_SYNC + H_BACK + H_ACTIVE + H_FRONT;
    localparam int V_TOTAL      = V_SYNC + V_BACK + V_ACTIVE + V_FRONT;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int FRAME_WORDS  = H_ACTIVE * V_ACTIVE;
    localparam int GROUPS       = 48;
    localparam int FIRST_LOAD   = 32;                 // one full frame before readout
    localparam int MAX_GAP      = 3;                  // two lfsr bits per gap
    localparam int RESET_CYCLES = 16;

    //////////////////////////////
    // run length budget
    //////////////////////////////
    localparam int STIM_CYCLES  = GROUPS * WORD_BYTES * (MAX_GAP + 1) + 8;
    localparam int KEY_CYCLES   = 12 * DEBOUNCE_CYCLES + 40;   // short press plus three presses and releases
    localparam int VIDEO_CYCLES = 4 * 3 * FRAME_CYCLES + 2 * FRAME_CYCLES;
    localparam int TIMEOUT_CYCLES =
        2 * (RESET_CYCLES + STIM_CYCLES + KEY_CYCLES + VIDEO_CYCLES);  // double for margin

    typedef struct packed {
        logic [0:WORD_BYTES-1][7:0] bytes;            // stream order
        rgb_t                       pix;              // first three bytes
    } group_t;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       key_in;
    byte_in_t   byte_in;
    logic       read_enable;
    video_t     video;

    group_t      stim [GROUPS];
    rgb_t        expected_mem [FRAME_WORDS];          // model of the frame memory
    logic [16:0] lfsr_state = 17'd96291;
    int          cycle_cnt = 0;
    int          start_wait;

    video_buffer_top #(
        .H_ACTIVE        (H_ACTIVE       ),
        .H_FRONT         (H_FRONT        ),
        .H_SYNC          (H_SYNC         ),
        .H_BACK          (H_BACK         ),
        .V_ACTIVE        (V_ACTIVE       ),
        .V_FRONT         (V_FRONT        ),
        .V_SYNC          (V_SYNC         ),
        .V_BACK          (V_BACK         ),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) uut (
        .clk         (clk        ),
        .rst_n       (rst_n      ),
        .key_in      (key_in     ),
        .byte_in     (byte_in    ),
        .read_enable (read_enable),
        .video       (video      )
    );

    always #4 clk = ~clk;                             // 8 ns period

    //////////////////////////////
    // failure and compare tasks
    //////////////////////////////
    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
        if (got !== exp) begin
            fail_now($sformatf("error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_now($sformatf("error: %s got %0h expected %0h", name, got, exp));
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_now("timeout: the test did not finish within its cycle budget");
        end
    end

    always @(negedge clk) begin
        if (uut.video_timing_inst.asserts_inst.fail_cnt != 0) begin
            fail_now("a concurrent assertion on the video timing failed");
        end
    end

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};              // x^17 + x^14 + 1
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        repeat (n) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);       // one step per bit
        end
    endtask

    task automatic build_table();
        int grp;
        int l;
        int v;
        for (grp = 0; grp < GROUPS; grp++) begin
            for (l = 0; l < WORD_BYTES; l++) begin
                take_bits(8, v);
                stim[grp].bytes[l] = 8'(v);
            end
            // pixel is bytes 0..2 and byte 3 is never shown
            stim[grp].pix = '{r: stim[grp].bytes[0], g: stim[grp].bytes[1],
                              b: stim[grp].bytes[2]};
        end
    endtask

    task automatic check_idle();
        check_bit("read_enable", read_enable, 1'b0);
        check_bit("video.de", video.de, 1'b0);
        check_bit("video.hsync", video.hsync, 1'b1);
        check_bit("video.vsync", video.vsync, 1'b1);
    endtask

    task automatic drive_cycle(input logic valid, input logic [7:0] data, input bit idle);
        @(negedge clk);
        if (idle) begin
            check_idle();                             // outputs must stay quiet
        end
        byte_in.valid = valid;
        byte_in.data  = data;
    endtask

    task automatic apply_groups(input int first, input int last, input bit idle);
        int grp;
        int l;
        int gap;
        for (grp = first; grp <= last; grp++) begin
            for (l = 0; l < WORD_BYTES; l++) begin
                take_bits(2, gap);                    // 0..MAX_GAP empty cycles
                repeat (gap) drive_cycle(1'b0, 8'hff, idle);
                drive_cycle(1'b1, stim[grp].bytes[l], idle);
            end
            expected_mem[grp % FRAME_WORDS] = stim[grp].pix;   // address wraps per frame
        end
        repeat (3) drive_cycle(1'b0, 8'hff, idle);    // let the last write land
    endtask

    //////////////////////////////
    // button handling
    //////////////////////////////
    task automatic short_press();
        @(negedge clk);
        key_in = 1'b0;
        repeat (DEBOUNCE_CYCLES / 2) @(negedge clk);
        key_in = 1'b1;                                // released before debounce
        repeat (2 * DEBOUNCE_CYCLES) begin
            @(negedge clk);
            check_bit("read_enable", read_enable, 1'b0);
        end
    endtask

    task automatic press_key(input logic exp_level);
        int held;
        held = 0;
        @(negedge clk);
        key_in = 1'b0;
        while (read_enable !== exp_level) begin
            @(negedge clk);
            held++;
            if (held > DEBOUNCE_CYCLES + 8) begin
                fail_now("read_enable did not toggle while the key was held down");
            end
        end
        if (held < DEBOUNCE_CYCLES) begin
            fail_now("read_enable toggled before the key was held for the debounce time");
        end
    endtask

    task automatic release_key(input logic exp_level);
        @(negedge clk);
        key_in = 1'b1;
        repeat (2 * DEBOUNCE_CYCLES + 4) begin       // release debounces too
            @(negedge clk);
            check_bit("read_enable", read_enable, exp_level);
        end
    endtask

    //////////////////////////////
    // frame capture from the ports
    //////////////////////////////
    task automatic capture_frame(output int waited);
        int   c;
        int   pix;
        int   line_de;
        int   hs_low;
        int   vs_low;
        int   de_lines;
        logic vs_prev;
        waited   = 0;
        pix      = 0;
        line_de  = 0;
        hs_low   = 0;
        vs_low   = 0;
        de_lines = 0;
        vs_prev  = video.vsync;
        @(negedge clk);
        while (!(vs_prev === 1'b1 && video.vsync === 1'b0)) begin   // frame starts at vsync fall
            waited++;
            if (waited > 2 * FRAME_CYCLES) begin
                fail_now("no frame start was seen on vsync");
            end
            vs_prev = video.vsync;
            @(negedge clk);
        end
        for (c = 0; c < FRAME_CYCLES; c++) begin
            if (c > 0) begin
                @(negedge clk);
            end
            if (!video.hsync) begin
                hs_low++;
            end
            if (!video.vsync) begin
                vs_low++;
            end
            if (video.de) begin
                if (pix < FRAME_WORDS) begin
                    check_rgb("video.rgb", video.rgb, expected_mem[pix]);  // k-th de is word k
                end
                pix++;
                line_de++;
            end
            if (c % H_TOTAL == H_TOTAL - 1) begin    // end of one line
                check_count("hsync low cycles per line", hs_low, H_SYNC);
                if (line_de != 0) begin
                    check_count("de cycles per line", line_de, H_ACTIVE);
                    de_lines++;
                end
                hs_low  = 0;
                line_de = 0;
            end
        end
        check_count("vsync low cycles per frame", vs_low, V_SYNC * H_TOTAL);
        check_count("lines with de per frame", de_lines, V_ACTIVE);
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////
    initial begin
        rst_n         = 1'b0;
        key_in        = 1'b1;                         // button released
        byte_in.valid = 1'b0;
        byte_in.data  = 8'h00;
        build_table();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        @(negedge clk);
        check_idle();                                 // quiet after reset
        apply_groups(0, FIRST_LOAD - 1, 1'b1);        // first frame while readout is off

        short_press();                                // too short to count
        press_key(1'b1);
        capture_frame(start_wait);
        if (start_wait > 4) begin
            fail_now("readout did not start its first frame right after enable");
        end
        capture_frame(start_wait);
        release_key(1'b1);

        apply_groups(FIRST_LOAD, GROUPS - 1, 1'b0);   // wraps over pixels 0..15
        capture_frame(start_wait);

        repeat ((V_SYNC + V_BACK) * H_TOTAL) @(negedge clk);   // off lands mid picture
        press_key(1'b0);
        repeat (FRAME_CYCLES) begin
            @(negedge clk);
            check_idle();
        end
        release_key(1'b0);

        press_key(1'b1);
        capture_frame(start_wait);                    // restart at pixel 0
        if (start_wait > 4) begin
            fail_now("readout did not restart at pixel 0 after the third press");
        end
        release_key(1'b1);

        if (uut.video_timing_inst.asserts_inst.fail_cnt == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            fail_now("a concurrent assertion on the video timing failed");
        end
    end

endmodule

// ==== dv/video_buffer_asserts.sv ====
`timescale 1ns/1ps

module video_buffer_asserts #(
    parameter int H_SYNC = video_pkg::DEF_H_SYNC
) (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     read_enable,
    input video_pkg::raster_state_e state,
    input video_pkg::video_t        video
);

    import video_pkg::*;

    localparam int RUN_W = 8;

    logic [RUN_W-1:0] hs_low_run;          // cycles hsync has been low
    int               fail_cnt = 0;        // polled by the testbench

    always_ff @(posedge clk) begin
        if (!rst_n || !read_enable) begin
            hs_low_run <= '0;
        end else if (!video.hsync) begin
            hs_low_run <= hs_low_run + 1'b1;
        end else begin
            hs_low_run <= '0;
        end
    end

    //////////////////////////////
    // raster output rules
    //////////////////////////////
    de_inside_sync_high: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(video.de) |-> (video.hsync && video.vsync))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("de rose while a sync was low");
        end

    idle_outputs_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (state == IDLE) |-> (video.hsync && video.vsync && !video.de))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("video outputs active while the raster is idle");
        end

    // full pulse only, a disable may cut one short
    hsync_pulse_width: assert property (@(posedge clk) disable iff (!rst_n || !read_enable)
        $rose(video.hsync) |-> (hs_low_run == RUN_W'(H_SYNC)))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("hsync low pulse has the wrong width");
        end

endmodule

bind video_timing video_buffer_asserts #(
    .H_SYNC (H_SYNC)
) asserts_inst (
    .clk         (clk        ),
    .rst_n       (rst_n      ),
    .read_enable (read_enable),
    .state       (state      ),
    .video       (video      )
);

// ==== hw/byte_packer.sv ====
`timescale 1ns/1ps

module byte_packer #(
    parameter int FRAME_WORDS = video_pkg::DEF_H_ACTIVE * video_pkg::DEF_V_ACTIVE
) (
    input  logic                clk,      // system clock
    input  logic                rst_n,    // sync reset
    input  video_pkg::byte_in_t byte_in,  // strobe plus byte, always accepted
    output video_pkg::wr_req_t  wr        // one write per four bytes
);

    import video_pkg::*;

    localparam int LANE_W = $clog2(WORD_BYTES);
    localparam int HEAD_W = (WORD_BYTES - 1) * 8;   // bytes held until the last lands
    localparam int WORD_W = WORD_BYTES * 8;
    localparam int ADDR_W = (FRAME_WORDS > 1) ? $clog2(FRAME_WORDS) : 1;

    logic [LANE_W-1:0] lane;        // byte position in the group
    logic [HEAD_W-1:0] head;        // earlier bytes, oldest on top
    logic              last_byte;   // fourth byte arriving now
    logic [ADDR_W-1:0] next_addr;   // address for the next word
    logic              wr_we;
    logic [ADDR_W-1:0] wr_addr;
    logic [WORD_W-1:0] wr_data;

    assign last_byte = byte_in.valid && (lane == LANE_W'(WORD_BYTES - 1));

    //////////////////////////////
    // byte collection
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lane <= '0;
        end else if (byte_in.valid) begin
            lane <= lane + 1'b1;                     // wraps after the fourth byte
        end
    end

    always_ff @(posedge clk) begin
        if (byte_in.valid) begin
            head <= {head[HEAD_W-9:0], byte_in.data}; // shift up, newest low
        end
    end

    //////////////////////////////
    // write request
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_we     <= 1'b0;
            wr_addr   <= '0;
            next_addr <= '0;
        end else begin
            wr_we <= last_byte;                      // one cycle pulse
            if (last_byte) begin
                wr_addr <= next_addr;
                // wrap at one frame
                next_addr <= (next_addr == ADDR_W'(FRAME_WORDS - 1)) ? '0
                                                                     : next_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (last_byte) begin
            wr_data <= {head, byte_in.data};         // first byte ends up in 31:24
        end
    end

    assign wr = '{we: wr_we, addr: 16'(wr_addr), data: wr_data};

endmodule

// ==== hw/frame_buffer.sv ====
`timescale 1ns/1ps

module frame_buffer #(
    parameter int FRAME_WORDS = video_pkg::DEF_H_ACTIVE * video_pkg::DEF_V_ACTIVE
) (
    input  logic               clk,      // system clock
    input  video_pkg::wr_req_t wr,       // write port from the packer
    input  logic [15:0]        rd_addr,  // read word address
    output logic [31:0]        rd_data   // valid one cycle after rd_addr
);

    import video_pkg::*;

    localparam int WORD_W = WORD_BYTES * 8;
    localparam int ADDR_W = (FRAME_WORDS > 1) ? $clog2(FRAME_WORDS) : 1;

    logic [WORD_W-1:0] mem [0:FRAME_WORDS-1];   // one frame of packed words
    logic [ADDR_W-1:0] wr_idx;                  // low bits of the write address
    logic [ADDR_W-1:0] rd_idx;                  // low bits of the read address

    assign wr_idx = wr.addr[ADDR_W-1:0];
    assign rd_idx = rd_addr[ADDR_W-1:0];

    //////////////////////////////
    // write port
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr_idx] <= wr.data;
        end
    end

    //////////////////////////////
    // registered read port
    //////////////////////////////
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_idx];                 // old data on same address collision
    end

endmodule

// ==== hw/key_toggle.sv ====
`timescale 1ns/1ps

module key_toggle #(
    parameter int DEBOUNCE_CYCLES = video_pkg::DEF_DEBOUNCE_CYCLES
) (
    input  logic clk,              // system clock
    input  logic rst_n,            // sync reset
    input  logic key_in,           // raw button, low when pressed
    output logic read_enable       // readout on/off state
);

    localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

    logic             key_meta;    // first sync flop
    logic             key_sync;    // second sync flop
    logic             key_db;      // debounced level
    logic             key_db_q;    // debounced level, last cycle
    logic [CNT_W-1:0] stable_cnt;  // cycles the new level has held
    logic             key_fall;    // debounced press seen

    //////////////////////////////
    // two flop synchronizer
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            key_meta <= 1'b1;      // released
            key_sync <= 1'b1;
        end else begin
            key_meta <= key_in;
            key_sync <= key_meta;
        end
    end

    //////////////////////////////
    // debounce counter
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stable_cnt <= '0;
            key_db     <= 1'b1;
        end else if (key_sync == key_db) begin
            stable_cnt <= '0;                          // bounce, start over
        end else if (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
            stable_cnt <= '0;
            key_db     <= key_sync;                    // held long enough
        end else begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

    assign key_fall = key_db_q & ~key_db;              // high to low on debounced level

    // toggle on every press
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            key_db_q    <= 1'b1;
            read_enable <= 1'b0;                       // readout off after reset
        end else begin
            key_db_q    <= key_db;
            read_enable <= read_enable ^ key_fall;
        end
    end

endmodule

// ==== hw/video_buffer_top.sv ====
`timescale 1ns/1ps

module video_buffer_top #(
    parameter int H_ACTIVE        = video_pkg::DEF_H_ACTIVE,
    parameter int H_FRONT         = video_pkg::DEF_H_FRONT,
    parameter int H_SYNC          = video_pkg::DEF_H_SYNC,
    parameter int H_BACK          = video_pkg::DEF_H_BACK,
    parameter int V_ACTIVE        = video_pkg::DEF_V_ACTIVE,
    parameter int V_FRONT         = video_pkg::DEF_V_FRONT,
    parameter int V_SYNC          = video_pkg::DEF_V_SYNC,
    parameter int V_BACK          = video_pkg::DEF_V_BACK,
    parameter int DEBOUNCE_CYCLES = video_pkg::DEF_DEBOUNCE_CYCLES
) (
    input  logic                clk,          // single system clock
    input  logic                rst_n,        // sync reset
    input  logic                key_in,       // readout button, active low
    input  video_pkg::byte_in_t byte_in,      // byte stream, no back-pressure
    output logic                read_enable,  // readout state
    output video_pkg::video_t   video         // raster output
);

    import video_pkg::*;

    localparam int FRAME_WORDS = H_ACTIVE * V_ACTIVE;   // one word per pixel

    wr_req_t     wr_req;       // packer to memory
    logic [15:0] rd_addr;      // timing to memory
    logic [31:0] rd_data;      // memory to timing

    //////////////////////////////
    // button control
    //////////////////////////////
    key_toggle #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) key_toggle_inst (
        .clk         (clk        ),
        .rst_n       (rst_n      ),
        .key_in      (key_in     ),
        .read_enable (read_enable)
    );

    //////////////////////////////
    // write path
    //////////////////////////////
    byte_packer #(
        .FRAME_WORDS (FRAME_WORDS)
    ) byte_packer_inst (
        .clk     (clk    ),
        .rst_n   (rst_n  ),
        .byte_in (byte_in),
        .wr      (wr_req )
    );

    frame_buffer #(
        .FRAME_WORDS (FRAME_WORDS)
    ) frame_buffer_inst (
        .clk     (clk    ),
        .wr      (wr_req ),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    //////////////////////////////
    // read path and raster
    //////////////////////////////
    video_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT ),
        .H_SYNC   (H_SYNC  ),
        .H_BACK   (H_BACK  ),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT ),
        .V_SYNC   (V_SYNC  ),
        .V_BACK   (V_BACK  )
    ) video_timing_inst (
        .clk         (clk        ),
        .rst_n       (rst_n      ),
        .read_enable (read_enable),   // off holds the raster at pixel 0
        .rd_addr     (rd_addr    ),
        .rd_data     (rd_data    ),
        .video       (video      )
    );

endmodule

// ==== hw/video_pkg.sv ====
package video_pkg;

    //////////////////////////////
    // default raster geometry
    //////////////////////////////
    localparam int DEF_H_ACTIVE = 8;         // visible pixels per line
    localparam int DEF_H_FRONT  = 2;         // horizontal front porch
    localparam int DEF_H_SYNC   = 3;         // hsync pulse width
    localparam int DEF_H_BACK   = 2;         // horizontal back porch

    localparam int DEF_V_ACTIVE = 4;         // visible lines per frame
    localparam int DEF_V_FRONT  = 1;         // vertical front porch, in lines
    localparam int DEF_V_SYNC   = 2;         // vsync pulse width, in lines
    localparam int DEF_V_BACK   = 1;         // vertical back porch, in lines

    localparam int DEF_DEBOUNCE_CYCLES = 16; // button must hold this long

    localparam int WORD_BYTES = 4;           // bytes per frame memory word

    //////////////////////////////
    // shared bundles
    //////////////////////////////
    typedef struct packed {
        logic       valid;                   // one byte this cycle
        logic [7:0] data;                    // byte from the stream source
    } byte_in_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        logic        we;                     // single cycle write strobe
        logic [15:0] addr;                   // word address, low bits used
        logic [31:0] data;                   // first byte in 31:24
    } wr_req_t;

    typedef struct packed {
        logic hsync;                         // active low
        logic vsync;                         // active low
        logic de;                            // active high
        rgb_t rgb;
    } video_t;

    typedef enum logic {
        IDLE,                                // readout off, raster held at zero
        RUN                                  // raster counting
    } raster_state_e;

endpackage

// ==== hw/video_timing.sv ====
`timescale 1ns/1ps

module video_timing #(
    parameter int H_ACTIVE = video_pkg::DEF_H_ACTIVE,
    parameter int H_FRONT  = video_pkg::DEF_H_FRONT,
    parameter int H_SYNC   = video_pkg::DEF_H_SYNC,
    parameter int H_BACK   = video_pkg::DEF_H_BACK,
    parameter int V_ACTIVE = video_pkg::DEF_V_ACTIVE,
    parameter int V_FRONT  = video_pkg::DEF_V_FRONT,
    parameter int V_SYNC   = video_pkg::DEF_V_SYNC,
    parameter int V_BACK   = video_pkg::DEF_V_BACK
) (
    input  logic              clk,          // pixel clock
    input  logic              rst_n,        // sync reset
    input  logic              read_enable,  // readout on, raster runs
    output logic [15:0]       rd_addr,      // frame memory read address
    input  logic [31:0]       rd_data,      // word one cycle after rd_addr
    output video_pkg::video_t video         // sync, de and rgb
);

    import video_pkg::*;

    localparam int H_TOTAL     = H_SYNC + H_BACK + H_ACTIVE + H_FRONT;
    localparam int V_TOTAL     = V_SYNC + V_BACK + V_ACTIVE + V_FRONT;
    localparam int H_ACT_BEG   = H_SYNC + H_BACK;       // first visible column
    localparam int H_ACT_END   = H_ACT_BEG + H_ACTIVE;  // one past the last
    localparam int V_ACT_BEG   = V_SYNC + V_BACK;
    localparam int V_ACT_END   = V_ACT_BEG + V_ACTIVE;
    localparam int FRAME_WORDS = H_ACTIVE * V_ACTIVE;
    localparam int H_W   = (H_TOTAL > 1) ? $clog2(H_TOTAL) : 1;
    localparam int V_W   = (V_TOTAL > 1) ? $clog2(V_TOTAL) : 1;
    localparam int PIX_W = (FRAME_WORDS > 1) ? $clog2(FRAME_WORDS) : 1;

    raster_state_e    state;
    logic [H_W-1:0]   h_cnt;        // column within the line
    logic [V_W-1:0]   v_cnt;        // line within the frame
    logic [PIX_W-1:0] pix_addr;     // next word to show
    logic             line_end;     // last column
    logic             frame_end;    // last column of the last line
    logic             running;
    logic             hsync_c, vsync_c, de_c;     // from the counters
    logic             hsync_d, vsync_d, de_d;     // aligned with rd_data
    logic             hsync_q, vsync_q, de_q;     // output register
    rgb_t             rgb_q;

    assign running   = (state == RUN);
    assign line_end  = (h_cnt == H_W'(H_TOTAL - 1));
    assign frame_end = line_end && (v_cnt == V_W'(V_TOTAL - 1));

    //////////////////////////////
    // raster position decode
    //////////////////////////////
    assign hsync_c = ~(running && (int'(h_cnt) < H_SYNC));   // low for the sync part
    assign vsync_c = ~(running && (int'(v_cnt) < V_SYNC));   // whole sync lines
    assign de_c    = running
                     && (int'(h_cnt) >= H_ACT_BEG) && (int'(h_cnt) < H_ACT_END)
                     && (int'(v_cnt) >= V_ACT_BEG) && (int'(v_cnt) < V_ACT_END);

    assign rd_addr = 16'(pix_addr);                          // read every cycle

    //////////////////////////////
    // state and counters
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n || !read_enable) begin
            state    <= IDLE;                                // held at pixel 0
            h_cnt    <= '0;
            v_cnt    <= '0;
            pix_addr <= '0;
        end else begin
            case (state)
                IDLE: state <= RUN;                          // counters already zero
                RUN: begin
                    h_cnt <= line_end ? '0 : h_cnt + 1'b1;
                    if (line_end) begin
                        v_cnt <= frame_end ? '0 : v_cnt + 1'b1;
                    end
                    if (frame_end) begin
                        pix_addr <= '0;                      // new frame starts at word 0
                    end else if (de_c) begin
                        pix_addr <= (pix_addr == PIX_W'(FRAME_WORDS - 1)) ? '0
                                                                          : pix_addr + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // delay controls one cycle to meet the memory data, then register all
    always_ff @(posedge clk) begin
        if (!rst_n || !read_enable) begin
            hsync_d <= 1'b1;
            vsync_d <= 1'b1;
            de_d    <= 1'b0;
            hsync_q <= 1'b1;                                 // inactive while off
            vsync_q <= 1'b1;
            de_q    <= 1'b0;
        end else begin
            hsync_d <= hsync_c;
            vsync_d <= vsync_c;
            de_d    <= de_c;
            hsync_q <= hsync_d;
            vsync_q <= vsync_d;
            de_q    <= de_d;
        end
    end

    always_ff @(posedge clk) begin
        rgb_q <= de_d ? rgb_t'(rd_data[31:8]) : '0;          // byte 7:0 dropped
    end

    assign video = '{hsync: hsync_q, vsync: vsync_q, de: de_q, rgb: rgb_q};

endmodule

// ==== vlog.f ====
hw/video_pkg.sv
hw/key_toggle.sv
hw/byte_packer.sv
hw/frame_buffer.sv
hw/video_timing.sv
hw/video_buffer_top.sv
dv/video_buffer_asserts.sv
dv/tb_video_buffer.sv
